//--- hw/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array (
	input  logic                 clk,
	input  logic [5:0]           rd_index,
	input  logic                 fill_valid,
	input  icache_pkg::way_vec_t fill_way,
	input  logic [5:0]           fill_index,
	input  icache_pkg::line_t    fill_line,
	output icache_pkg::line_t    way_data [icache_pkg::num_ways]
);

	//////////////////////////////////////////////////////////////////////
	// Line storage
	//////////////////////////////////////////////////////////////////////

	icache_pkg::line_t line_mem [icache_pkg::num_ways][icache_pkg::num_sets];

	// Only the way named by the tag array takes the new line.
	always_ff @(posedge clk) begin
		for (int w = 0; w < icache_pkg::num_ways; w++) begin
			if (fill_valid && fill_way[w]) begin
				line_mem[w][fill_index] <= fill_line;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Every way is read each cycle. Validity is decided by the tag array.
	always_ff @(posedge clk) begin
		for (int w = 0; w < icache_pkg::num_ways; w++) begin
			way_data[w] <= line_mem[w][rd_index];
		end
	end

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

	//////////////////////////////////////////////////////////////////////
	// Cache geometry
	//////////////////////////////////////////////////////////////////////

	localparam int num_ways = 4;
	localparam int num_sets = 64;
	localparam int tag_bits = 22;
	localparam int index_bits = 6; // log2 of num_sets.
	localparam int words_per_line = 4;
	localparam int word_bits = 32;
	localparam int word_off_bits = $clog2(words_per_line);
	localparam int byte_off_bits = 2;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	// One memory word, the size of an AXI4-Lite data beat.
	typedef logic [word_bits-1:0] word_t;

	// Fetch address. The raw view goes to the bus, the field view drives lookup.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] index;
			logic [word_off_bits-1:0] word;
			logic [byte_off_bits-1:0] byte_off;
		} f;
	} fetch_addr_t;

	// Word 0 sits in the low bits of the line.
	typedef word_t [words_per_line-1:0] line_t;

	typedef logic [num_ways-1:0] way_vec_t; // One-hot.

endpackage

//--- hw/icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush,
	input  logic                    miss_start,
	input  icache_pkg::fetch_addr_t miss_addr,
	output logic                    refill_busy,
	output logic                    fill_valid,
	output icache_pkg::fetch_addr_t fill_addr,
	output icache_pkg::line_t       fill_line,
	output logic [31:0]             m_araddr,
	output logic                    m_arvalid,
	input  logic                    m_arready,
	input  logic [31:0]             m_rdata,
	input  logic [1:0]              m_rresp,
	input  logic                    m_rvalid,
	output logic                    m_rready
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_done = 2'd3;

	logic [1:0] state;
	logic [1:0] beat;
	logic flush_seen;
	logic last_beat;

	//////////////////////////////////////////////////////////////////////
	// Refill state machine
	//////////////////////////////////////////////////////////////////////

	assign last_beat = (beat == 2'(icache_pkg::words_per_line - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			beat <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (miss_start) begin
						state <= st_addr;
						beat <= '0;
					end
				end
				st_addr: begin
					if (m_arready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (m_rvalid) begin
						beat <= beat + 1'b1;
						state <= last_beat ? st_done : st_addr;
					end
				end
				default: state <= st_idle; // Done lasts a single cycle.
			endcase
		end
	end

	// A flush during the refill makes the line stale, so it is not installed.
	always_ff @(posedge clk) begin
		if (rst) begin
			flush_seen <= 1'b0;
		end else if (state == st_idle) begin
			flush_seen <= 1'b0;
		end else if (flush) begin
			flush_seen <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Line address and data
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == st_idle && miss_start) begin
			fill_addr.raw <= {miss_addr.raw[31:4], 4'b0000}; // Line base.
		end
		if (state == st_data && m_rvalid) begin
			fill_line[beat] <= m_rdata; // The response code is not checked.
		end
	end

	assign m_araddr = {fill_addr.raw[31:4], beat, 2'b00};
	assign m_arvalid = (state == st_addr);
	assign m_rready = (state == st_data);

	assign refill_busy = (state != st_idle);
	assign fill_valid = (state == st_done) && !flush_seen;

endmodule

//--- hw/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array (
	input  logic                   clk,
	input  logic                   rst,
	input  icache_pkg::fetch_addr_t fetch_addr,
	input  logic                   flush,
	input  logic                   fill_valid,
	input  icache_pkg::fetch_addr_t fill_addr,
	output icache_pkg::way_vec_t   way_hit,
	output logic                   hit,
	output icache_pkg::way_vec_t   fill_way
);

	localparam int ptr_bits = $clog2(icache_pkg::num_ways);

	logic [icache_pkg::tag_bits-1:0] tag_mem [icache_pkg::num_ways][icache_pkg::num_sets];
	logic [icache_pkg::num_sets-1:0] valid [icache_pkg::num_ways];
	logic [ptr_bits-1:0] repl_ptr;

	//////////////////////////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////////////////////////

	// All ways are compared in parallel against the tag field.
	always_comb begin
		for (int w = 0; w < icache_pkg::num_ways; w++) begin
			way_hit[w] = valid[w][fetch_addr.f.index] &&
				(tag_mem[w][fetch_addr.f.index] == fetch_addr.f.tag);
		end
	end

	assign hit = |way_hit;

	//////////////////////////////////////////////////////////////////////
	// Fill and replacement
	//////////////////////////////////////////////////////////////////////

	assign fill_way = icache_pkg::way_vec_t'(1) << repl_ptr; // Victim is the pointer way.

	always_ff @(posedge clk) begin
		if (fill_valid) begin
			tag_mem[repl_ptr][fill_addr.f.index] <= fill_addr.f.tag;
		end
	end

	// A flush wins over a fill landing on the same edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < icache_pkg::num_ways; w++) begin
				valid[w] <= '0;
			end
			repl_ptr <= '0;
		end else if (flush) begin
			for (int w = 0; w < icache_pkg::num_ways; w++) begin
				valid[w] <= '0;
			end
		end else if (fill_valid) begin
			valid[repl_ptr][fill_addr.f.index] <= 1'b1;
			repl_ptr <= repl_ptr + 1'b1; // Wraps from way 3 back to way 0.
		end
	end

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ps

module icache_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] fetch_addr,
	input  logic        fetch_valid,
	input  logic        flush,
	output logic        fetch_ready,
	output logic [31:0] inst,
	output logic        inst_valid,
	output logic [31:0] m_araddr,
	output logic        m_arvalid,
	input  logic        m_arready,
	input  logic [31:0] m_rdata,
	input  logic [1:0]  m_rresp,
	input  logic        m_rvalid,
	output logic        m_rready
);

	icache_pkg::fetch_addr_t fetch_u;
	icache_pkg::fetch_addr_t fill_addr;
	icache_pkg::way_vec_t way_hit;
	icache_pkg::way_vec_t fill_way;
	icache_pkg::line_t fill_line;
	icache_pkg::line_t way_data [icache_pkg::num_ways];
	logic hit;
	logic accept;
	logic miss_start;
	logic refill_busy;
	logic fill_valid;

	//////////////////////////////////////////////////////////////////////
	// Handshake gates
	//////////////////////////////////////////////////////////////////////

	assign fetch_u.raw = fetch_addr;

	assign fetch_ready = hit && !refill_busy;
	assign accept = fetch_valid && fetch_ready;
	assign miss_start = fetch_valid && !hit && !refill_busy;

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	icache_tag_array u_tag_array (
		.clk(clk), .rst(rst),
		.fetch_addr(fetch_u), .flush(flush),
		.fill_valid(fill_valid), .fill_addr(fill_addr),
		.way_hit(way_hit), .hit(hit), .fill_way(fill_way)
	);

	icache_data_array u_data_array (
		.clk(clk), .rd_index(fetch_u.f.index),
		.fill_valid(fill_valid), .fill_way(fill_way),
		.fill_index(fill_addr.f.index), .fill_line(fill_line),
		.way_data(way_data)
	);

	icache_way_select u_way_select (
		.clk(clk), .rst(rst), .flush(flush), .accept(accept),
		.way_hit(way_hit), .fetch_addr(fetch_u), .way_data(way_data),
		.inst(inst), .inst_valid(inst_valid)
	);

	icache_refill u_refill (
		.clk(clk), .rst(rst), .flush(flush),
		.miss_start(miss_start), .miss_addr(fetch_u),
		.refill_busy(refill_busy), .fill_valid(fill_valid),
		.fill_addr(fill_addr), .fill_line(fill_line),
		.m_araddr(m_araddr), .m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_rdata(m_rdata), .m_rresp(m_rresp), .m_rvalid(m_rvalid),
		.m_rready(m_rready)
	);

endmodule

//--- hw/icache_way_select.sv
`timescale 1ns/1ps

module icache_way_select (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush,
	input  logic                    accept,
	input  icache_pkg::way_vec_t    way_hit,
	input  icache_pkg::fetch_addr_t fetch_addr,
	input  icache_pkg::line_t       way_data [icache_pkg::num_ways],
	output logic [31:0]             inst,
	output logic                    inst_valid
);

	icache_pkg::way_vec_t hit_q;
	logic [icache_pkg::word_off_bits-1:0] word_q;
	icache_pkg::line_t line_sel;

	//////////////////////////////////////////////////////////////////////
	// Lookup stage registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			hit_q <= way_hit;
			word_q <= fetch_addr.f.word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= accept;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output mux
	//////////////////////////////////////////////////////////////////////

	// The hit vector is one-hot, so at most one way is picked.
	always_comb begin
		line_sel = '0;
		for (int w = 0; w < icache_pkg::num_ways; w++) begin
			if (hit_q[w]) begin
				line_sel = way_data[w];
			end
		end
	end

	assign inst = line_sel[word_q];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f tb.f -o icache_sim \
	|| { echo "Build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1 || echo "Simulator exited with a failing status"
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: run ended without a result"; exit 1; }
echo "PASS"

//--- sim/icache_properties.sv
`timescale 1ns/1ps

module icache_properties (
	input logic        clk,
	input logic        rst,
	input logic        flush,
	input logic        fetch_valid,
	input logic        fetch_ready,
	input logic        inst_valid,
	input logic        refill_busy,
	input logic        fill_valid,
	input logic [31:0] m_araddr,
	input logic        m_arvalid,
	input logic        m_arready
);

	// The arrays belong to the refill engine until it goes idle.
	ready_while_busy: assert property (@(posedge clk) disable iff (rst)
		!(fetch_ready && refill_busy))
		else $error("fetch_ready is high while refill_busy is high");

	araddr_stable: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && !m_arready |=> $stable(m_araddr))
		else $error("m_araddr changed while the read address was waiting");

	inst_after_accept: assert property (@(posedge clk) disable iff (rst)
		fetch_valid && fetch_ready && !flush |=> inst_valid)
		else $error("inst_valid did not follow an accepted fetch");

	inst_only_after_accept: assert property (@(posedge clk) disable iff (rst)
		inst_valid |-> $past(fetch_valid && fetch_ready))
		else $error("inst_valid without an accepted fetch one cycle before");

	fill_single_cycle: assert property (@(posedge clk) disable iff (rst)
		fill_valid |=> !fill_valid)
		else $error("fill_valid lasted more than one cycle");

endmodule

//--- sim/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

	localparam int timeout_cycles = 20000; // About 600 fetches at up to 30 cycles each.
	localparam logic [31:0] rand_seed = 32'h18c99ccb;

	logic clk;
	logic rst = 1'b1;
	logic [31:0] fetch_addr = '0;
	logic fetch_valid = 1'b0;
	logic flush = 1'b0;
	logic fetch_ready;
	logic [31:0] inst;
	logic inst_valid;
	logic [31:0] m_araddr;
	logic m_arvalid;
	logic m_arready = 1'b0;
	logic [31:0] m_rdata = '0;
	logic [1:0] m_rresp = 2'b00;
	logic m_rvalid = 1'b0;
	logic m_rready;

	logic [31:0] exp_q [$]; // Accepted fetch addresses, oldest first.
	int cycle_count = 0;
	int ar_count = 0;
	int r_count = 0;
	int compare_count = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_err_base = 0;
	int test_cmp_base = 0;

	logic ar_fire = 1'b0;
	logic r_fire = 1'b0;
	logic r_pending = 1'b0;
	logic [31:0] rd_addr = '0;
	int ar_wait = 0;
	int r_wait = 0;

	tb_clock clk_gen_i (.clk(clk));

	icache_top dut_i (
		.clk(clk), .rst(rst),
		.fetch_addr(fetch_addr), .fetch_valid(fetch_valid), .flush(flush),
		.fetch_ready(fetch_ready), .inst(inst), .inst_valid(inst_valid),
		.m_araddr(m_araddr), .m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_rdata(m_rdata), .m_rresp(m_rresp), .m_rvalid(m_rvalid), .m_rready(m_rready)
	);

	bind icache_top icache_properties props_i (
		.clk(clk), .rst(rst), .flush(flush),
		.fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .inst_valid(inst_valid),
		.refill_busy(refill_busy), .fill_valid(fill_valid),
		.m_araddr(m_araddr), .m_arvalid(m_arvalid), .m_arready(m_arready)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Memory content is the address rotated left by 7, scrambled by a constant.
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[24:0], addr[31:25]} ^ 32'h5a3c96e1;
	endfunction

	function automatic logic [31:0] expected_inst(input logic [31:0] addr);
		return mem_word({addr[31:2], 2'b00});
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Handshake monitor and AXI4-Lite read slave
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count++;
		if (!rst) begin
			if (fetch_valid && fetch_ready) begin
				exp_q.push_back(fetch_addr);
			end
			if (m_arvalid && m_arready) begin
				ar_count++;
				rd_addr = m_araddr;
				ar_fire = 1'b1;
			end
			if (m_rvalid && m_rready) begin
				r_count++;
				r_fire = 1'b1;
			end
		end
	end

	// One read in flight at a time, each side delayed 0 to 3 cycles.
	always @(negedge clk) begin
		if (ar_fire) begin
			m_arready = 1'b0;
			ar_fire = 1'b0;
			r_pending = 1'b1;
			r_wait = int'($urandom_range(3, 0));
			ar_wait = int'($urandom_range(3, 0));
		end else if (m_arvalid && !m_arready) begin
			if (ar_wait == 0) begin
				m_arready = 1'b1;
			end else begin
				ar_wait--;
			end
		end
		if (r_fire) begin
			m_rvalid = 1'b0;
			r_fire = 1'b0;
		end else if (r_pending) begin
			if (r_wait == 0) begin
				m_rvalid = 1'b1;
				m_rdata = mem_word(rd_addr);
				r_pending = 1'b0;
			end else begin
				r_wait--;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checker
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin : compare_proc
		logic [31:0] addr;
		logic [31:0] expected;
		if (!rst && inst_valid) begin
			if (exp_q.size() == 0) begin
				$display("inst_valid was high with no accepted fetch pending at cycle %0d",
					cycle_count);
				error_count++;
			end else begin
				addr = exp_q.pop_front();
				expected = expected_inst(addr);
				compare_count++;
				if (inst !== expected) begin
					$display("** Error: inst at address %h: expected %h, got %h",
						addr, expected, inst);
					error_count++;
				end
			end
		end
	end

	task automatic check_count_value(input string what, input int expected, input int actual);
		check_count++;
		if (actual != expected) begin
			$display("** Error: %s: expected %h, got %h", what, expected, actual);
			error_count++;
		end
	endtask

	task automatic start_test();
		test_err_base = error_count;
		test_cmp_base = compare_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("Test %s: %0d compares, %0d errors", name,
			compare_count - test_cmp_base, error_count - test_err_base);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Core side stimulus
	//////////////////////////////////////////////////////////////////////

	// Called on a falling edge. Returns on the falling edge after acceptance.
	task automatic fetch_word(input logic [31:0] addr);
		fetch_addr = addr;
		fetch_valid = 1'b1;
		@(posedge clk);
		while (!fetch_ready) begin
			@(posedge clk);
		end
		@(negedge clk);
	endtask

	task automatic drain_pipeline();
		fetch_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
	endtask

	initial begin : watchdog
		wait (cycle_count >= timeout_cycles);
		$display("Timeout: the run did not complete within %0d cycles", timeout_cycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin : stimulus
		int ar_base;
		int r_base;
		int cmp_base;
		int start_cycle;
		void'($urandom(rand_seed));
		ar_wait = int'($urandom_range(3, 0));
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		start_test();
		ar_base = ar_count;
		for (int i = 0; i < 64; i++) begin
			fetch_word(32'h0000_1000 + 32'(4 * i));
		end
		drain_pipeline();
		check_count_value("AR handshakes", 64, ar_count - ar_base); // 16 lines, 4 reads each.
		end_test("cold_miss");

		start_test();
		ar_base = ar_count;
		start_cycle = cycle_count;
		for (int i = 0; i < 64; i++) begin
			fetch_word(32'h0000_1000 + 32'(4 * i));
		end
		check_count_value("fetch cycles", 64, cycle_count - start_cycle);
		drain_pipeline();
		check_count_value("AR handshakes", 0, ar_count - ar_base);
		end_test("hit");

		// Lines A to E share set 0x30 and differ only in tag.
		start_test();
		for (int k = 0; k < 5; k++) begin
			fetch_word(32'h0004_0300 + 32'(k * 32'h400) + 32'(4 * (k % 4)));
		end
		drain_pipeline();
		ar_base = ar_count;
		for (int k = 3; k >= 1; k--) begin
			fetch_word(32'h0004_0300 + 32'(k * 32'h400));
		end
		drain_pipeline();
		check_count_value("AR handshakes", 0, ar_count - ar_base);
		ar_base = ar_count;
		fetch_word(32'h0004_0300);
		drain_pipeline();
		check_count_value("AR handshakes", 4, ar_count - ar_base);
		end_test("replacement");

		start_test();
		pulse_flush();
		ar_base = ar_count;
		for (int i = 0; i < 4; i++) begin
			fetch_word(32'h0000_1000 + 32'(4 * i));
		end
		drain_pipeline();
		check_count_value("AR handshakes", 4, ar_count - ar_base);
		// Start a miss, then flush while its line is on the bus.
		ar_base = ar_count;
		r_base = r_count;
		fetch_addr = 32'h0000_2040;
		fetch_valid = 1'b1;
		@(negedge clk);
		fetch_valid = 1'b0;
		while (ar_count == ar_base) begin
			@(negedge clk);
		end
		pulse_flush();
		while (r_count < r_base + 4) begin
			@(negedge clk);
		end
		ar_base = ar_count;
		fetch_word(32'h0000_2048);
		drain_pipeline();
		check_count_value("AR handshakes", 4, ar_count - ar_base);
		end_test("flush");

		start_test();
		cmp_base = compare_count;
		for (int n = 0; n < 300; n++) begin
			fetch_word(32'h0000_8000 + (32'($urandom_range(1023, 0)) << 2));
			if ($urandom_range(3, 0) == 0) begin
				fetch_valid = 1'b0; // An idle cycle now and then.
				@(negedge clk);
			end
		end
		drain_pipeline();
		check_count_value("compares", 300, compare_count - cmp_base);
		end_test("random");

		$display("Tests: %0d, checks: %0d, compares: %0d, errors: %0d",
			test_count, check_count, compare_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	localparam time half_period = 20; // 40 ns period.

	initial begin
		clk = 1'b0;
		forever begin
			#(half_period) clk = ~clk;
		end
	end

endmodule

//--- tb.f
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_way_select.sv
hw/icache_refill.sv
hw/icache_top.sv
sim/tb_clock.sv
sim/icache_properties.sv
sim/icache_tb.sv
